// File: project.f
+incdir+src
src/icache_pkg.sv
src/icache_way_array.sv
src/icache_lookup.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_l2_model.sv
tb/icache_tb.sv

// File: tb/icache_tb.sv
`timescale 1ns/100ps

module icache_tb
    import icache_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 1;     // inputs change this long after the edge
    localparam int N_ENTRIES  = 16;

    typedef struct packed {
        fetch_addr_t addr;
        logic        miss;      // one next-level request expected
        logic        lat_chk;   // hit must ack on the second edge
        logic [1:0]  hold;      // extra cycles fetch_req stays up after ack
        logic        imm;       // next level answers with no delay
    } stim_t;

    logic       clk;
    logic       arst_n;
    logic       fetch_req;
    fetch_addr_t fetch_addr;
    logic       fetch_ack;
    word_t      fetch_data;
    logic       l2_req;
    line_addr_t l2_addr;
    logic       l2_ack;
    line_t      l2_line;
    logic       no_wait;
    int         req_count;

    stim_t stim [N_ENTRIES];
    int    err_data;
    int    err_req;
    int    err_lat;
    int    err_hold;

    icache_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_ack     (l2_ack),
        .l2_line    (l2_line)
    );

    icache_l2_model #(.SEED(32'h88ee)) l2_i (
        .clk       (clk),
        .no_wait   (no_wait),
        .l2_req    (l2_req),
        .l2_addr   (l2_addr),
        .l2_ack    (l2_ack),
        .l2_line   (l2_line),
        .req_count (req_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic stim_t entry(input logic [19:0] tag, input logic [7:0] index,
                                    input logic [1:0] offset, input logic miss,
                                    input logic lat_chk, input logic [1:0] hold,
                                    input logic imm);
        stim_t s;
        s.addr    = '{tag: tag, index: index, offset: offset};
        s.miss    = miss;
        s.lat_chk = lat_chk;
        s.hold    = hold;
        s.imm     = imm;
        return s;
    endfunction

    // word address plus the fixed next-level offset
    function automatic word_t expect_word(input fetch_addr_t a);
        return {2'b00, a} + 32'h1000_0000;
    endfunction

    // one four-phase fetch with edges counted up to the ack
    task automatic run_fetch(input stim_t s, output word_t data, output int edges);
        no_wait    = s.imm;
        fetch_addr = s.addr;
        fetch_req  = 1'b1;
        edges      = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
        end while (!fetch_ack);
        data = fetch_data;
        repeat (s.hold) begin          // ack and data must stay put
            @(posedge clk);
            #DRIVE_DLY;
            assert (fetch_ack === 1'b1) else begin
                err_hold++;
                $display("ERR %0t fetch_ack expected 1 actual %b", $time, fetch_ack);
            end
            assert (fetch_data === data) else begin
                err_hold++;
                $display("ERR %0t fetch_data expected %h actual %h",
                         $time, data, fetch_data);
            end
        end
        fetch_req = 1'b0;
        while (fetch_ack) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    ////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////

    initial begin
        stim_t s;
        word_t data;
        int    edges;
        int    count_before;
        arst_n     = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        no_wait    = 1'b0;
        err_data   = 0;
        err_req    = 0;
        err_lat    = 0;
        err_hold   = 0;

        //                 tag        index  off  miss lat hold imm
        stim[0]  = entry(20'h00012, 8'h3c, 2'd1, 1, 0, 0, 0);  // cold miss into way 0
        stim[1]  = entry(20'h00012, 8'h3c, 2'd2, 0, 1, 0, 0);
        stim[2]  = entry(20'h00012, 8'h3c, 2'd3, 0, 1, 3, 0);
        stim[3]  = entry(20'h00345, 8'h3c, 2'd0, 1, 0, 0, 0);  // fills way 1
        stim[4]  = entry(20'h00012, 8'h3c, 2'd0, 0, 1, 0, 0);
        stim[5]  = entry(20'h00345, 8'h3c, 2'd1, 0, 1, 0, 0);
        stim[6]  = entry(20'h00012, 8'h3c, 2'd2, 0, 1, 0, 0);  // 00345 now lru
        stim[7]  = entry(20'h06789, 8'h3c, 2'd0, 1, 0, 0, 0);  // evicts 00345
        stim[8]  = entry(20'h00012, 8'h3c, 2'd3, 0, 1, 0, 0);  // survivor
        stim[9]  = entry(20'h00345, 8'h3c, 2'd2, 1, 0, 0, 1);  // evicted line
        stim[10] = entry(20'h00345, 8'h3c, 2'd3, 0, 1, 2, 0);
        stim[11] = entry(20'h06789, 8'h81, 2'd0, 1, 0, 2, 1);
        stim[12] = entry(20'h06789, 8'h81, 2'd1, 0, 1, 0, 0);
        stim[13] = entry(20'hfffff, 8'hff, 2'd3, 1, 0, 0, 0);
        stim[14] = entry(20'h00000, 8'h00, 2'd0, 1, 0, 1, 0);
        stim[15] = entry(20'h00000, 8'h00, 2'd1, 0, 1, 0, 0);

        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        for (int i = 0; i < N_ENTRIES; i++) begin
            s            = stim[i];
            count_before = req_count;
            run_fetch(s, data, edges);
            assert (data === expect_word(s.addr)) else begin
                err_data++;
                $display("ERR %0t fetch_data expected %h actual %h",
                         $time, expect_word(s.addr), data);
            end
            assert ((req_count - count_before) == (s.miss ? 1 : 0)) else begin
                err_req++;
                $display("ERR %0t l2_req count expected %0d actual %0d",
                         $time, s.miss ? 1 : 0, req_count - count_before);
            end
            if (s.lat_chk) begin
                assert (edges == 2) else begin
                    err_lat++;
                    $display("ERR %0t fetch_ack latency expected 2 actual %0d",
                             $time, edges);
                end
            end
        end

        $display("errors: data %0d, requests %0d, latency %0d, hold %0d",
                 err_data, err_req, err_lat, err_hold);
        if ((err_data + err_req + err_lat + err_hold) == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // 20 cycles per fetch covers the longest miss
    initial begin
        #(N_ENTRIES * 20 * CLK_PERIOD);
        $display("run timed out before all fetches were acknowledged");
        $display("Test failed");
        $finish;
    end

endmodule

// File: tb/icache_l2_model.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_l2_model
    import icache_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h88ee
) (
    input  logic       clk,
    input  logic       no_wait,      // answer in the cycle the request is seen
    input  logic       l2_req,
    input  line_addr_t l2_addr,
    output logic       l2_ack,
    output line_t      l2_line,
    output int         req_count
);

    logic [31:0] lfsr;
    int          delay;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // word i holds its own word address plus a fixed offset
    function automatic line_t make_line(input line_addr_t la);
        line_t l;
        for (int i = 0; i < `IC_WORDS; i++) begin
            l[i*`IC_WORD_W +: `IC_WORD_W] = {2'b00, la, i[1:0]} + 32'h1000_0000;
        end
        return l;
    endfunction

    // one lfsr step per delay bit
    task automatic draw_delay(output int d);
        d = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_step(lfsr);
            d    = (d << 1) | lfsr[0];
        end
    endtask

    ////////////////////////////////////////
    // four-phase responder
    ////////////////////////////////////////

    initial begin
        lfsr      = SEED;
        l2_ack    = 1'b0;
        l2_line   = '0;
        req_count = 0;
        forever begin
            @(posedge clk);
            #1;
            if (l2_req && !l2_ack) begin
                req_count = req_count + 1;
                draw_delay(delay);
                if (no_wait) begin
                    delay = 0;
                end
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                l2_line = make_line(l2_addr);
                l2_ack  = 1'b1;
                while (l2_req) begin     // cache drops req after seeing ack
                    @(posedge clk);
                    #1;
                end
                l2_ack = 1'b0;
            end
        end
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // cpu side
    input  logic        fetch_req,
    input  fetch_addr_t fetch_addr,
    output logic        fetch_ack,
    output word_t       fetch_data,
    // next level
    output logic        l2_req,
    output line_addr_t  l2_addr,
    input  logic        l2_ack,
    input  line_t       l2_line
);

    logic    rd_en;
    index_t  rd_index;
    logic    acc_en;
    fill_t   fill;
    lookup_t result;
    tag_t    tag_way0;
    tag_t    tag_way1;
    line_t   line_way0;
    line_t   line_way1;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    icache_ctrl ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_ack     (l2_ack),
        .l2_line    (l2_line),
        .result     (result),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .acc_en     (acc_en),
        .fill       (fill)
    );

    ////////////////////////////////////////
    // lookup and arrays
    ////////////////////////////////////////

    icache_lookup lookup_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr   (fetch_addr),   // held by the cpu through the request
        .acc_en    (acc_en),
        .tag_way0  (tag_way0),
        .tag_way1  (tag_way1),
        .line_way0 (line_way0),
        .line_way1 (line_way1),
        .fill      (fill),
        .result    (result)
    );

    icache_way_array #(.payload_t(tag_t)) tag_array_i (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .fill(fill),
        .wr_data(fill.tag), .rd_way0(tag_way0), .rd_way1(tag_way1)
    );

    icache_way_array #(.payload_t(line_t)) data_array_i (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .fill(fill),
        .wr_data(fill.line), .rd_way0(line_way0), .rd_way1(line_way1)
    );

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // cpu side
    input  logic        fetch_req,
    input  fetch_addr_t fetch_addr,
    output logic        fetch_ack,
    output word_t       fetch_data,
    // next level
    output logic        l2_req,
    output line_addr_t  l2_addr,
    input  logic        l2_ack,
    input  line_t       l2_line,
    // lookup and arrays
    input  lookup_t     result,
    output logic        rd_en,
    output index_t      rd_index,
    output logic        acc_en,
    output fill_t       fill
);

    ic_state_e                            state_q;
    logic                                 victim_q;     // way picked at the miss
    logic                                 fill_we_q;
    line_t                                fill_line_q;
    logic [`IC_WORDS-1:0][`IC_WORD_W-1:0] l2_words;
    word_t                                fwd_word;

    ////////////////////////////////////////
    // array read and lookup strobes
    ////////////////////////////////////////

    // read starts as soon as a request shows up in IDLE
    assign rd_en    = (state_q == IDLE) && fetch_req;
    assign rd_index = fetch_addr.index;

    // lru touch on a hit
    assign acc_en = (state_q == ACCESS) && result.hit;

    ////////////////////////////////////////
    // refill path
    ////////////////////////////////////////

    // requested word straight from the arriving line
    assign l2_words = l2_line;
    assign fwd_word = l2_words[fetch_addr.offset];

    // index and tag come from the held line address
    assign fill = '{
        we:    fill_we_q,
        way:   victim_q,
        index: l2_addr.index,
        tag:   l2_addr.tag,
        line:  fill_line_q
    };

    ////////////////////////////////////////
    // FSM and handshakes
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= IDLE;
            fetch_ack <= 1'b0;
            l2_req    <= 1'b0;
            fill_we_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (fetch_req) begin
                        state_q <= ACCESS;      // arrays read on this edge
                    end
                end
                ACCESS: begin
                    if (result.hit) begin
                        fetch_ack <= 1'b1;
                        state_q   <= WRITE;
                    end else begin
                        l2_req  <= 1'b1;        // l2_ack already low after WRITE
                        state_q <= WAIT_FILL;
                    end
                end
                WAIT_FILL: begin
                    if (l2_ack) begin
                        l2_req    <= 1'b0;
                        fill_we_q <= 1'b1;      // arrays write next edge
                        state_q   <= WRITE;
                    end
                end
                WRITE: begin
                    if (fill_we_q) begin
                        fill_we_q <= 1'b0;
                        fetch_ack <= 1'b1;      // same edge as the array write
                    end else if (!fetch_req || !fetch_ack) begin
                        fetch_ack <= 1'b0;
                        // wait out the next level before a new fetch
                        if (!l2_ack) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // payload registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state_q == ACCESS) begin
            if (result.hit) begin
                fetch_data <= result.word;
            end else begin
                victim_q <= result.victim_way;
                l2_addr  <= '{tag: fetch_addr.tag, index: fetch_addr.index};
            end
        end
        if ((state_q == WAIT_FILL) && l2_ack) begin
            fill_line_q <= l2_line;
            fetch_data  <= fwd_word;    // ready one edge before fetch_ack
        end
    end

    // fetch_data and fetch_ack hold in WRITE
    // until the cpu lets go of fetch_req

endmodule

// File: src/icache_lookup.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_lookup
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  fetch_addr_t rd_addr,
    input  logic        acc_en,
    input  tag_t        tag_way0,
    input  tag_t        tag_way1,
    input  line_t       line_way0,
    input  line_t       line_way1,
    input  fill_t       fill,
    output lookup_t     result
);

    fetch_addr_t                         addr_q;     // address of the read in flight
    logic [1:0][`IC_SETS-1:0]            valid_q;    // [way][set]
    logic [`IC_SETS-1:0]                 lru_q;      // names the way to evict next
    logic                                valid0;
    logic                                valid1;
    logic                                hit0;
    logic                                hit1;
    line_t                               hit_line;
    logic [`IC_WORDS-1:0][`IC_WORD_W-1:0] hit_words;

    ////////////////////////////////////////
    // address register
    ////////////////////////////////////////

    // follows the array read, same edge
    always_ff @(posedge clk) begin
        addr_q <= rd_addr;
    end

    ////////////////////////////////////////
    // tag compare and word select
    ////////////////////////////////////////

    assign valid0 = valid_q[0][addr_q.index];
    assign valid1 = valid_q[1][addr_q.index];

    assign hit0 = valid0 && (tag_way0 == addr_q.tag);
    assign hit1 = valid1 && (tag_way1 == addr_q.tag);

    always_comb begin
        result.hit     = hit0 | hit1;
        result.hit_way = !hit0;                     // way 0 wins a double match

        hit_line    = result.hit_way ? line_way1 : line_way0;
        hit_words   = hit_line;
        result.word = hit_words[addr_q.offset];

        // empty ways go first, then LRU
        if (!valid0) begin
            result.victim_way = 1'b0;
        end else if (!valid1) begin
            result.victim_way = 1'b1;
        end else begin
            result.victim_way = lru_q[addr_q.index];
        end
    end

    ////////////////////////////////////////
    // valid and LRU state
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (fill.we) begin
            valid_q[fill.way][fill.index] <= 1'b1;
            lru_q[fill.index]             <= ~fill.way;   // other way is now older
        end else if (acc_en && result.hit) begin
            lru_q[addr_q.index] <= ~result.hit_way;
        end
    end

    // fill and hit-accept never share a cycle,
    // the controller is in WRITE or ACCESS, not both

endmodule

// File: src/icache_way_array.sv
`timescale 1ns/100ps

`include "icache_defines.svh"

module icache_way_array
    import icache_pkg::*;
#(
    parameter type payload_t = tag_t
) (
    input  logic     clk,
    input  logic     rd_en,
    input  index_t   rd_index,
    input  fill_t    fill,
    input  payload_t wr_data,
    output payload_t rd_way0,
    output payload_t rd_way1
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // bank[way][set]
    payload_t bank [0:1][0:`IC_SETS-1];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // one way per fill, the other way keeps its entry
    always_ff @(posedge clk) begin
        if (fill.we) begin
            bank[fill.way][fill.index] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    // both ways of the set come out together, one edge after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_way0 <= bank[0][rd_index];
            rd_way1 <= bank[1][rd_index];
        end
    end

    // outputs hold between reads so the lookup
    // sees a stable pair during ACCESS

endmodule

// File: src/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    ////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////

    typedef logic [`IC_WORD_W-1:0]   word_t;
    typedef logic [`IC_TAG_W-1:0]    tag_t;
    typedef logic [`IC_INDEX_W-1:0]  index_t;
    typedef logic [`IC_OFFSET_W-1:0] offset_t;
    typedef logic [`IC_LINE_W-1:0]   line_t;   // word 0 in the low bits

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } fetch_addr_t;                 // 30 bits

    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;                  // line address to the next level

    typedef struct packed {
        logic   we;                 // write strobe for tag and data arrays
        logic   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

    typedef struct packed {
        logic  hit;
        logic  hit_way;
        logic  victim_way;          // way to replace on a miss
        word_t word;                // word of the hit way
    } lookup_t;

    typedef enum logic [1:0] {IDLE, ACCESS, WAIT_FILL, WRITE} ic_state_e;

endpackage

// File: src/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

////////////////////////////////////////
// word and address widths
////////////////////////////////////////

`define IC_WORD_W    32   // one instruction
`define IC_ADDR_W    30   // word address, byte bits dropped

////////////////////////////////////////
// address split
////////////////////////////////////////

// tag | index | offset, msb first
`define IC_OFFSET_W  2    // word inside a line
`define IC_INDEX_W   8    // set select
`define IC_TAG_W     20   // what is left of the word address

////////////////////////////////////////
// geometry
////////////////////////////////////////

`define IC_WORDS     4    // words per line
`define IC_SETS      256  // sets per way
`define IC_LINE_W    128  // IC_WORDS * IC_WORD_W

`endif
